// File: Bender.yml
package:
  name: rv_backend

sources:
  - include_dirs:
      - src
    files:
      - src/data_pkg.sv
      - src/uop_pkg.sv
      - src/stage_if.sv
      - src/wb_bus_if.sv
      - src/exu.sv
      - src/lsu.sv
      - src/data_ram.sv
      - src/wbu.sv
      - src/rv_backend.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/rv_backend_chk.sv
      - tests/rv_backend_tb.sv

// File: rv_backend.f
+incdir+src
src/data_pkg.sv
src/uop_pkg.sv
src/stage_if.sv
src/wb_bus_if.sv
src/exu.sv
src/lsu.sv
src/data_ram.sv
src/wbu.sv
src/rv_backend.sv
tests/rv_backend_chk.sv
tests/rv_backend_tb.sv

// File: src/backend_config.svh
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// integer data width
`define BACKEND_XLEN 64
// general register count
`define BACKEND_NREGS 32
// data ram depth in doublewords and its index width
`define BACKEND_RAM_WORDS 256
`define BACKEND_RAM_AW 8

`endif

// File: src/data_pkg.sv
`default_nettype none

package data_pkg;
	`include "backend_config.svh"

	typedef logic [`BACKEND_XLEN-1:0] xlen_t;
	typedef logic [`BACKEND_XLEN-1:0] pc_t;
	// register index, 32 registers
	typedef logic [4:0] reg_id_t;
	// doubleword index into data ram
	typedef logic [`BACKEND_RAM_AW-1:0] ram_idx_t;
endpackage

`default_nettype wire

// File: src/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module data_ram
	import data_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	wb_bus_if.slave   bus
);
	xlen_t mem [`BACKEND_RAM_WORDS];
	logic  req;

	// new request, not yet answered
	assign req = bus.cyc && bus.stb && !bus.ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			bus.ack <= 1'b0;
			for (int i = 0; i < `BACKEND_RAM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else begin
			bus.ack <= req;
			if (req && bus.we) begin
				mem[bus.adr] <= bus.dat_w;
			end
		end
	end

	// read data lines up with ack
	always_ff @(posedge clk) begin
		if (req) begin
			bus.dat_r <= mem[bus.adr];
		end
	end
endmodule

`default_nettype wire

// File: src/exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu
	import data_pkg::*;
	import uop_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     issue_valid,
	output logic          issue_ready,
	input  wire pc_t      issue_pc,
	input  wire op_kind_t issue_kind,
	input  wire reg_id_t  issue_rd,
	input  wire xlen_t    issue_rs1,
	input  wire xlen_t    issue_rs2,
	input  wire xlen_t    issue_imm,
	stage_if.producer     out
);
	logic  take;
	xlen_t result;

	// output register empty or drained this cycle
	assign issue_ready = !out.valid || out.ready;
	assign take = issue_valid && issue_ready;

	always_comb begin
		case (issue_kind)
			OP_ADD:   result = issue_rs1 + issue_rs2;
			OP_SUB:   result = issue_rs1 - issue_rs2;
			OP_AND:   result = issue_rs1 & issue_rs2;
			OP_OR:    result = issue_rs1 | issue_rs2;
			OP_XOR:   result = issue_rs1 ^ issue_rs2;
			// effective address
			OP_LOAD,
			OP_STORE: result = issue_rs1 + issue_imm;
			default:  result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out.valid <= 1'b0;
		end else if (issue_ready) begin
			out.valid <= issue_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out.pc         <= issue_pc;
			out.kind       <= issue_kind;
			out.rd         <= issue_rd;
			out.value      <= result;
			out.store_data <= issue_rs2;
		end
	end
endmodule

`default_nettype wire

// File: src/lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module lsu
	import data_pkg::*;
	import uop_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst,
	stage_if.consumer  in,
	stage_if.producer  out,
	wb_bus_if.master   bus
);
	lsu_state_t state;
	logic       out_free;
	logic       take;
	logic       is_mem;
	logic       bus_done;

	// operation held while its bus cycle runs
	pc_t        req_pc;
	op_kind_t   req_kind;
	reg_id_t    req_rd;
	xlen_t      req_addr;

	assign out_free = !out.valid || out.ready;
	assign in.ready = (state == LSU_IDLE) && out_free;
	assign take     = in.valid && in.ready;
	assign is_mem   = (in.kind == OP_LOAD) || (in.kind == OP_STORE);
	assign bus_done = (state == LSU_BUS) && bus.ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= LSU_IDLE;
			bus.cyc <= 1'b0;
			bus.stb <= 1'b0;
		end else begin
			case (state)
				LSU_IDLE: begin
					if (take && is_mem) begin
						state   <= LSU_BUS;
						bus.cyc <= 1'b1;
						bus.stb <= 1'b1;
					end
				end
				LSU_BUS: begin
					if (bus.ack) begin
						state   <= LSU_IDLE;
						bus.cyc <= 1'b0;
						bus.stb <= 1'b0;
					end
				end
				default: state <= LSU_IDLE;
			endcase
		end
	end

	// request fields, held until ack
	always_ff @(posedge clk) begin
		if (take && is_mem) begin
			bus.we    <= (in.kind == OP_STORE);
			bus.adr   <= in.value[`BACKEND_RAM_AW+2:3];
			bus.dat_w <= in.store_data;
			req_pc    <= in.pc;
			req_kind  <= in.kind;
			req_rd    <= in.rd;
			req_addr  <= in.value;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out.valid <= 1'b0;
		end else if ((take && !is_mem) || bus_done) begin
			out.valid <= 1'b1;
		end else if (out.ready) begin
			out.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take && !is_mem) begin
			// alu ops skip the bus
			out.pc         <= in.pc;
			out.kind       <= in.kind;
			out.rd         <= in.rd;
			out.value      <= in.value;
			out.store_data <= in.store_data;
		end else if (bus_done) begin
			out.pc         <= req_pc;
			out.kind       <= req_kind;
			out.rd         <= req_rd;
			out.value      <= (req_kind == OP_LOAD) ? bus.dat_r : req_addr;
			out.store_data <= bus.dat_w;
		end
	end
endmodule

`default_nettype wire

// File: src/rv_backend.sv
`timescale 1ns/1ps
`default_nettype none

module rv_backend
	import data_pkg::*;
	import uop_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,

	// decoded issue port
	input  wire logic     issue_valid,
	output logic          issue_ready,
	input  wire pc_t      issue_pc,
	input  wire op_kind_t issue_kind,
	input  wire reg_id_t  issue_rd,
	input  wire xlen_t    issue_rs1,
	input  wire xlen_t    issue_rs2,
	input  wire xlen_t    issue_imm,

	// one pulse per retired op
	output logic          retire_valid,
	output pc_t           retire_pc,
	output reg_id_t       retire_rd,
	output logic          retire_wen,
	output xlen_t         retire_data,

	input  wire reg_id_t  dbg_rd,
	output xlen_t         dbg_data
);
	stage_if  ex_mem ();
	stage_if  mem_wb ();
	wb_bus_if ram_bus ();

	exu u_exu (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue_pc    (issue_pc),
		.issue_kind  (issue_kind),
		.issue_rd    (issue_rd),
		.issue_rs1   (issue_rs1),
		.issue_rs2   (issue_rs2),
		.issue_imm   (issue_imm),
		.out         (ex_mem.producer)
	);

	lsu u_lsu (
		.clk (clk),
		.rst (rst),
		.in  (ex_mem.consumer),
		.out (mem_wb.producer),
		.bus (ram_bus.master)
	);

	data_ram u_data_ram (
		.clk (clk),
		.rst (rst),
		.bus (ram_bus.slave)
	);

	wbu u_wbu (
		.clk          (clk),
		.rst          (rst),
		.in           (mem_wb.consumer),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_rd    (retire_rd),
		.retire_wen   (retire_wen),
		.retire_data  (retire_data),
		.dbg_rd       (dbg_rd),
		.dbg_data     (dbg_data)
	);
endmodule

`default_nettype wire

// File: src/stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// one operation between pipeline stages, valid/ready handshake
interface stage_if
	import data_pkg::*;
	import uop_pkg::*;
();
	logic     valid;
	logic     ready;
	pc_t      pc;
	op_kind_t kind;
	reg_id_t  rd;
	// alu result, or effective address for memory ops
	xlen_t    value;
	xlen_t    store_data;

	modport producer (
		output valid, pc, kind, rd, value, store_data,
		input  ready
	);

	modport consumer (
		input  valid, pc, kind, rd, value, store_data,
		output ready
	);
endinterface

`default_nettype wire

// File: src/uop_pkg.sv
`default_nettype none

package uop_pkg;
	// operation kinds after decode
	typedef enum logic [2:0] {
		OP_ADD   = 3'd0,
		OP_SUB   = 3'd1,
		OP_AND   = 3'd2,
		OP_OR    = 3'd3,
		OP_XOR   = 3'd4,
		OP_LOAD  = 3'd5,
		OP_STORE = 3'd6
	} op_kind_t;

	// memory stage fsm
	typedef enum logic {
		LSU_IDLE = 1'b0,
		LSU_BUS  = 1'b1
	} lsu_state_t;
endpackage

`default_nettype wire

// File: src/wb_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// wishbone classic, memory stage to data ram
interface wb_bus_if
	import data_pkg::*;
();
	logic     cyc;
	logic     stb;
	logic     we;
	ram_idx_t adr;
	xlen_t    dat_w;
	xlen_t    dat_r;
	logic     ack;

	modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);

	modport slave (input cyc, stb, we, adr, dat_w, output dat_r, ack);
endinterface

`default_nettype wire

// File: src/wbu.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module wbu
	import data_pkg::*;
	import uop_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rst,
	stage_if.consumer    in,
	output logic         retire_valid,
	output pc_t          retire_pc,
	output reg_id_t      retire_rd,
	output logic         retire_wen,
	output xlen_t        retire_data,
	input  wire reg_id_t dbg_rd,
	output xlen_t        dbg_data
);
	logic    wb_valid;
	logic    wb_wen;
	pc_t     wb_pc;
	reg_id_t wb_rd;
	xlen_t   wb_data;
	logic    in_wen;
	xlen_t   gpr [`BACKEND_NREGS];

	// never stalls
	assign in.ready = 1'b1;

	// stores write nothing, x0 stays zero
	assign in_wen = (in.kind != OP_STORE) && (in.rd != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			for (int i = 0; i < `BACKEND_NREGS; i++) begin
				gpr[i] <= '0;
			end
		end else begin
			wb_valid <= in.valid;
			if (in.valid && in_wen) begin
				gpr[in.rd] <= in.value;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid) begin
			wb_wen  <= in_wen;
			wb_pc   <= in.pc;
			wb_rd   <= in.rd;
			wb_data <= in.value;
		end
	end

	assign retire_valid = wb_valid;
	assign retire_wen   = wb_valid && wb_wen;
	assign retire_pc    = wb_pc;
	assign retire_rd    = wb_rd;
	assign retire_data  = wb_data;

	assign dbg_data = (dbg_rd == '0) ? '0 : gpr[dbg_rd];
endmodule

`default_nettype wire

// File: tests/rv_backend_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rv_backend_chk
	import data_pkg::*;
	import uop_pkg::*;
(
	input wire logic       clk,
	input wire logic       rst,
	input wire logic       cyc,
	input wire logic       stb,
	input wire logic       we,
	input wire ram_idx_t   adr,
	input wire logic       ack,
	input wire lsu_state_t state
);
	// strobe only inside a bus cycle
	stb_in_cycle: assert property (@(posedge clk) disable iff (rst) stb |-> cyc)
		else $error("wishbone stb raised without cyc");

	// request held until the slave answers
	req_stable: assert property (@(posedge clk) disable iff (rst)
		(cyc && !ack) |=> (cyc && $stable(adr) && $stable(we)))
		else $error("wishbone request changed before ack");

	ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
		else $error("wishbone ack held longer than one cycle");

	cyc_in_bus_state: assert property (@(posedge clk) disable iff (rst)
		cyc |-> (state == LSU_BUS))
		else $error("bus cycle active outside LSU_BUS");
endmodule

bind lsu rv_backend_chk u_chk (
	.clk   (clk),
	.rst   (rst),
	.cyc   (bus.cyc),
	.stb   (bus.stb),
	.we    (bus.we),
	.adr   (bus.adr),
	.ack   (bus.ack),
	.state (state)
);

`default_nettype wire

// File: tests/rv_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module rv_backend_tb
	import data_pkg::*;
	import uop_pkg::*;
();
	localparam int CLK_PERIOD = 20;
	localparam int NROWS      = 28;

	typedef struct {
		op_kind_t kind;
		reg_id_t  rd;
		xlen_t    rs1;
		xlen_t    rs2;
		xlen_t    imm;
		int       gap;
	} row_t;

	typedef struct {
		pc_t     pc;
		reg_id_t rd;
		logic    wen;
		xlen_t   data;
	} expect_t;

	logic        clk;
	logic        rst;
	logic        issue_valid;
	logic        issue_ready;
	pc_t         issue_pc;
	op_kind_t    issue_kind;
	reg_id_t     issue_rd;
	xlen_t       issue_rs1;
	xlen_t       issue_rs2;
	xlen_t       issue_imm;
	logic        retire_valid;
	pc_t         retire_pc;
	reg_id_t     retire_rd;
	logic        retire_wen;
	xlen_t       retire_data;
	reg_id_t     dbg_rd;
	xlen_t       dbg_data;

	row_t        stim_rows [NROWS];
	int          nrows_filled;
	expect_t     exp_q [$];
	xlen_t       model_regs [`BACKEND_NREGS];
	xlen_t       model_mem [`BACKEND_RAM_WORDS];
	logic [31:0] lfsr;

	rv_backend UUT (
		.clk          (clk),
		.rst          (rst),
		.issue_valid  (issue_valid),
		.issue_ready  (issue_ready),
		.issue_pc     (issue_pc),
		.issue_kind   (issue_kind),
		.issue_rd     (issue_rd),
		.issue_rs1    (issue_rs1),
		.issue_rs2    (issue_rs2),
		.issue_imm    (issue_imm),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_rd    (retire_rd),
		.retire_wen   (retire_wen),
		.retire_data  (retire_data),
		.dbg_rd       (dbg_rd),
		.dbg_data     (dbg_data)
	);

	always #(CLK_PERIOD/2) clk = !clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic xlen_t random_word();
		xlen_t w;
		for (int b = 0; b < `BACKEND_XLEN; b++) begin
			lfsr = lfsr_next(lfsr);
			w[b] = lfsr[0];
		end
		return w;
	endfunction

	function automatic pc_t pc_of(input int i);
		return 64'h1000 + pc_t'(i) * 4;
	endfunction

	task automatic value_error(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic run_error(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic add_row(input op_kind_t kind, input reg_id_t rd, input xlen_t imm,
			input int gap);
		stim_rows[nrows_filled].kind = kind;
		stim_rows[nrows_filled].rd   = rd;
		stim_rows[nrows_filled].imm  = imm;
		stim_rows[nrows_filled].gap  = gap;
		nrows_filled++;
	endtask

	task automatic build_table();
		add_row(OP_ADD, 5'd1, '0, 0);
		add_row(OP_SUB, 5'd2, '0, 0);
		add_row(OP_AND, 5'd3, '0, 0);
		add_row(OP_OR, 5'd4, '0, 0);
		add_row(OP_XOR, 5'd5, '0, 0);
		add_row(OP_ADD, 5'd0, '0, 0);
		add_row(OP_STORE, 5'd3, 64'h08, 1);
		add_row(OP_STORE, 5'd4, 64'h10, 0);
		add_row(OP_LOAD, 5'd6, 64'h08, 0);
		add_row(OP_LOAD, 5'd7, 64'h10, 0);
		add_row(OP_ADD, 5'd8, '0, 0);
		// never written, reads the cleared ram
		add_row(OP_LOAD, 5'd9, 64'h18, 0);
		// low address bits ignored, same doubleword as 0x08
		add_row(OP_STORE, 5'd0, 64'h0f, 2);
		add_row(OP_LOAD, 5'd10, 64'h08, 0);
		add_row(OP_SUB, 5'd11, '0, 0);
		add_row(OP_XOR, 5'd0, '0, 0);
		add_row(OP_STORE, 5'd1, 64'h7f8, 0);
		add_row(OP_LOAD, 5'd12, 64'h7f8, 0);
		add_row(OP_OR, 5'd13, '0, 2);
		add_row(OP_AND, 5'd14, '0, 0);
		add_row(OP_LOAD, 5'd15, 64'h10, 0);
		add_row(OP_STORE, 5'd2, 64'h20, 1);
		add_row(OP_ADD, 5'd16, '0, 0);
		add_row(OP_LOAD, 5'd17, 64'h20, 0);
		add_row(OP_LOAD, 5'd0, 64'h20, 0);
		add_row(OP_XOR, 5'd1, '0, 0);
		add_row(OP_SUB, 5'd31, '0, 3);
		add_row(OP_LOAD, 5'd18, 64'h0, 0);
		for (int i = 0; i < NROWS; i++) begin
			if (stim_rows[i].kind == OP_LOAD || stim_rows[i].kind == OP_STORE) begin
				stim_rows[i].rs1 = 64'h400;
			end else begin
				stim_rows[i].rs1 = random_word();
			end
			stim_rows[i].rs2 = random_word();
		end
	endtask

	// reference model, updated in issue order
	task automatic model_issue(input int i);
		row_t    r;
		expect_t e;
		xlen_t   addr;
		r      = stim_rows[i];
		addr   = r.rs1 + r.imm;
		e.pc   = pc_of(i);
		e.rd   = r.rd;
		e.wen  = (r.kind != OP_STORE) && (r.rd != 5'd0);
		case (r.kind)
			OP_ADD:  e.data = r.rs1 + r.rs2;
			OP_SUB:  e.data = r.rs1 - r.rs2;
			OP_AND:  e.data = r.rs1 & r.rs2;
			OP_OR:   e.data = r.rs1 | r.rs2;
			OP_XOR:  e.data = r.rs1 ^ r.rs2;
			OP_LOAD: e.data = model_mem[addr[10:3]];
			// a store retires with its address
			default: e.data = addr;
		endcase
		if (r.kind == OP_STORE) begin
			model_mem[addr[10:3]] = r.rs2;
		end
		if (e.wen) begin
			model_regs[r.rd] = e.data;
		end
		exp_q.push_back(e);
	endtask

	task automatic issue_row(input int i);
		logic rdy;
		if (stim_rows[i].gap > 0) begin
			issue_valid <= 1'b0;
			repeat (stim_rows[i].gap) @(posedge clk);
		end
		issue_valid <= 1'b1;
		issue_pc    <= pc_of(i);
		issue_kind  <= stim_rows[i].kind;
		issue_rd    <= stim_rows[i].rd;
		issue_rs1   <= stim_rows[i].rs1;
		issue_rs2   <= stim_rows[i].rs2;
		issue_imm   <= stim_rows[i].imm;
		do begin
			@(negedge clk);
			rdy = issue_ready;
			@(posedge clk);
		end while (!rdy);
		model_issue(i);
	endtask

	task automatic check_retire();
		expect_t e;
		if (exp_q.size() == 0) begin
			run_error("retire seen with no operation outstanding");
		end else begin
			e = exp_q.pop_front();
			assert (retire_pc == e.pc)
				else value_error($sformatf("retire pc %h, expected %h", retire_pc, e.pc));
			assert (retire_rd == e.rd)
				else value_error($sformatf("retire rd %0d, expected %0d", retire_rd, e.rd));
			assert (retire_wen == e.wen)
				else value_error($sformatf("pc %h retire wen %b, expected %b",
					e.pc, retire_wen, e.wen));
			assert (retire_data == e.data)
				else value_error($sformatf("pc %h retire data %h, expected %h",
					e.pc, retire_data, e.data));
		end
	endtask

	// register file sweep through the debug port
	task automatic check_registers();
		for (int r = 0; r < `BACKEND_NREGS; r++) begin
			dbg_rd <= reg_id_t'(r);
			@(negedge clk);
			assert (dbg_data == model_regs[r])
				else value_error($sformatf("x%0d reads %h, expected %h",
					r, dbg_data, model_regs[r]));
			@(posedge clk);
		end
	endtask

	always @(negedge clk) begin
		if (!rst && retire_valid) begin
			check_retire();
		end
	end

	initial begin
		#(NROWS * 10 * CLK_PERIOD);
		run_error($sformatf("timeout: run still going after %0d ns",
			NROWS * 10 * CLK_PERIOD));
	end

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		issue_valid  = 1'b0;
		issue_pc     = '0;
		issue_kind   = OP_ADD;
		issue_rd     = '0;
		issue_rs1    = '0;
		issue_rs2    = '0;
		issue_imm    = '0;
		dbg_rd       = '0;
		lfsr         = 32'hc9ee9cb8;
		nrows_filled = 0;
		for (int i = 0; i < `BACKEND_NREGS; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < `BACKEND_RAM_WORDS; i++) begin
			model_mem[i] = '0;
		end
		build_table();

		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (!retire_valid && issue_ready)
			else value_error("pipeline not idle after reset");
		@(posedge clk);
		check_registers();

		for (int i = 0; i < NROWS; i++) begin
			issue_row(i);
		end
		issue_valid <= 1'b0;
		wait (exp_q.size() == 0);
		// catch any extra retire
		repeat (10) @(posedge clk);
		check_registers();

		$display("Result: PASSED");
		$finish;
	end
endmodule

`default_nettype wire
